// File: sources.f
design/legv8_pkg.sv
design/id_ex_if.sv
design/register_file.sv
design/decode_stage.sv
design/id_ex.sv
design/execute_stage.sv
design/decode_execute_top.sv
testbench/decode_execute_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module decode_execute_tb \
   -f sources.f -Mdir obj_dir -o decode_execute_sim > build.log 2>&1 \
   && ./obj_dir/decode_execute_sim > sim.log 2>&1 \
   || { cat build.log; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1

// File: testbench/decode_execute_tb.sv
`timescale 1ns/1ns

module decode_execute_tb;

   localparam logic [10:0] R_OPS [4] = '{legv8_pkg::OP_ADD, legv8_pkg::OP_SUB,
                                          legv8_pkg::OP_AND, legv8_pkg::OP_ORR};

   logic        clock;
   logic        reset;
   logic [31:0] instr_i;
   logic [63:0] pc_i;
   logic        flush_i;
   logic        wb_en_i;
   logic [3:0]  wb_reg_i;
   logic [63:0] wb_data_i;
   logic [63:0] alu_result_o, store_data_o, branch_target_o;
   logic        mem_read_o, mem_write_o, mem2reg_o, reg_write_o, branch_taken_o;
   logic [3:0]  write_reg_o, ex_rn_o, ex_rm_o;
   logic [4:0]  ctl;
   logic [63:0] shadow [16] = '{default: '0};
   logic [63:0] rng = 64'd48;
   int          checks = 0;
   int          errors = 0;

   decode_execute_top #(.DATA_WIDTH(64)) uut (.*);

   // {mem_read, mem_write, mem2reg, reg_write, branch_taken}
   assign ctl = {mem_read_o, mem_write_o, mem2reg_o, reg_write_o, branch_taken_o};

   initial
   begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   function automatic logic [63:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 7);
      rng = rng ^ (rng << 17);
      return rng;
   endfunction

   task automatic compare(input string name, input logic [63:0] want, input logic [63:0] got);
      checks++;
      assert (got === want)
      else
      begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, want, got);
      end
   endtask

   // drive one cycle, then sample past the capture edge
   task automatic send(input logic [31:0] instr, input logic [63:0] pc, input logic flush,
                       input logic wb_en, input logic [3:0] wb_reg, input logic [63:0] wb_data);
      @(posedge clock);
      instr_i   <= instr;
      pc_i      <= pc;
      flush_i   <= flush;
      wb_en_i   <= wb_en;
      wb_reg_i  <= wb_reg;
      wb_data_i <= wb_data;
      // a same-cycle write is seen by the decoding instruction
      if (wb_en)
         shadow[wb_reg] = wb_data;
      @(posedge clock);
      flush_i <= 1'b0;
      wb_en_i <= 1'b0;
      @(negedge clock);
   endtask

   initial
   begin
      for (int n = 0; n < 1000; n++)
      begin
         @(posedge clock);
      end
      $display("timeout, stimulus did not finish within 1000 cycles");
      $display("Some tests failed");
      $finish;
   end

   initial
   begin
      logic [63:0] r;
      logic [63:0] a;
      logic [63:0] want;
      logic [8:0]  off;
      logic [18:0] boff;
      logic [4:0]  rt;
      reset     = 1'b1;
      instr_i   = '0;
      pc_i      = '0;
      flush_i   = 1'b0;
      wb_en_i   = 1'b0;
      wb_reg_i  = '0;
      wb_data_i = '0;
      repeat (3) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      compare("controls", 64'd0, 64'(ctl));

      // registers are still clear
      send({legv8_pkg::OP_ORR, 5'd3, 6'd0, 5'd9, 5'd1}, 64'd0, 1'b0, 1'b0, 4'd0, 64'd0);
      compare("alu_result_o", 64'd0, alu_result_o);
      compare("store_data_o", 64'd0, store_data_o);
      for (int k = 0; k < 16; k++)
      begin
         send(32'd0, 64'd0, 1'b0, 1'b1, k[3:0], next_rand());
      end

      // R-type, the last four passes also write rn in the decode cycle
      for (int k = 0; k < 12; k++)
      begin
         r = next_rand();
         send({R_OPS[k[1:0]], r[4:0], 6'd0, r[9:5], r[14:10]}, r, 1'b0, k >= 8, r[8:5], ~r);
         a = shadow[r[8:5]];
         case (k[1:0])
            2'd0: want = a + shadow[r[3:0]];
            2'd1: want = a - shadow[r[3:0]];
            2'd2: want = a & shadow[r[3:0]];
            default: want = a | shadow[r[3:0]];
         endcase
         compare("alu_result_o", want, alu_result_o);
         compare("controls", 64'd2, 64'(ctl));
         compare("write_reg_o", 64'(r[13:10]), 64'(write_reg_o));
         compare("ex_rn_o", 64'(r[8:5]), 64'(ex_rn_o));
         compare("ex_rm_o", 64'(r[3:0]), 64'(ex_rm_o));
      end

      // immediates, then loads on odd passes and stores on even ones
      for (int k = 0; k < 8; k++)
      begin
         r = next_rand();
         send({k[0] ? legv8_pkg::OP_SUBI : legv8_pkg::OP_ADDI, r[31:20], r[9:5], r[14:10]},
              r, 1'b0, 1'b0, 4'd0, 64'd0);
         a = shadow[r[8:5]];
         want = k[0] ? a - {52'd0, r[31:20]} : a + {52'd0, r[31:20]};
         compare("alu_result_o", want, alu_result_o);
         compare("controls", 64'd2, 64'(ctl));
         // passes 2, 3, 6 and 7 get a negative offset
         off = {k[1] | r[40], r[39:32]};
         send({k[0] ? legv8_pkg::OP_LDUR : legv8_pkg::OP_STUR, off, 2'b00, r[9:5], r[14:10]},
              r, 1'b0, 1'b0, 4'd0, 64'd0);
         compare("alu_result_o", a + {{55{off[8]}}, off}, alu_result_o);
         compare("controls", k[0] ? 64'd22 : 64'd8, 64'(ctl));
         compare("write_reg_o", 64'(r[13:10]), 64'(write_reg_o));
         compare("store_data_o", shadow[r[13:10]], store_data_o);
      end

      // CBZ on a clear and a nonzero register, forward and backward
      send(32'd0, 64'd0, 1'b0, 1'b1, 4'd7, 64'd0);
      send(32'd0, 64'd0, 1'b0, 1'b1, 4'd2, next_rand() | 64'd1);
      for (int k = 0; k < 4; k++)
      begin
         r = next_rand();
         rt = {r[63], k[0] ? 4'd7 : 4'd2};
         boff = {k[1], r[17:0]};
         send({legv8_pkg::OP_CBZ, boff, rt}, r, 1'b0, 1'b0, 4'd0, 64'd0);
         compare("branch_taken_o", 64'(shadow[rt[3:0]] == 64'd0), 64'(branch_taken_o));
         compare("branch_target_o", r + ({{45{boff[18]}}, boff} << 2), branch_target_o);
         compare("reg_write_o", 64'd0, 64'(reg_write_o));
      end

      // flushed load and unknown opcode give bubbles, then a normal ADD
      send({legv8_pkg::OP_LDUR, 9'd8, 2'b00, 5'd1, 5'd2}, 64'd0, 1'b1, 1'b0, 4'd0, 64'd0);
      compare("controls", 64'd0, 64'(ctl));
      send(32'hFFFF_FFFF, 64'd0, 1'b0, 1'b0, 4'd0, 64'd0);
      compare("controls", 64'd0, 64'(ctl));
      send({legv8_pkg::OP_ADD, 5'd3, 6'd0, 5'd4, 5'd5}, 64'd0, 1'b0, 1'b0, 4'd0, 64'd0);
      compare("alu_result_o", shadow[4] + shadow[3], alu_result_o);
      compare("controls", 64'd2, 64'(ctl));

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: design/decode_execute_top.sv
`timescale 1ns/1ns

module decode_execute_top
#(
   parameter int DATA_WIDTH = 64
)
(
   input  logic                             clock,
   input  logic                             reset,
   input  logic [31:0]                      instr_i,
   input  logic [DATA_WIDTH-1:0]            pc_i,
   input  logic                             flush_i,
   input  logic                             wb_en_i,
   input  logic [legv8_pkg::REG_IDX_W-1:0]  wb_reg_i,
   input  logic [DATA_WIDTH-1:0]            wb_data_i,
   output logic [DATA_WIDTH-1:0]            alu_result_o,
   output logic [DATA_WIDTH-1:0]            store_data_o,
   output logic                             mem_read_o,
   output logic                             mem_write_o,
   output logic                             mem2reg_o,
   output logic                             reg_write_o,
   output logic [legv8_pkg::REG_IDX_W-1:0]  write_reg_o,
   output logic                             branch_taken_o,
   output logic [DATA_WIDTH-1:0]            branch_target_o,
   output logic [legv8_pkg::REG_IDX_W-1:0]  ex_rn_o,
   output logic [legv8_pkg::REG_IDX_W-1:0]  ex_rm_o
);

   id_ex_if #(.DATA_WIDTH(DATA_WIDTH)) dec_if ();
   id_ex_if #(.DATA_WIDTH(DATA_WIDTH)) ex_if ();

   decode_stage #(.DATA_WIDTH(DATA_WIDTH)) decode (
      .clock     (clock),
      .reset     (reset),
      .instr_i   (instr_i),
      .pc_i      (pc_i),
      .wb_en_i   (wb_en_i),
      .wb_reg_i  (wb_reg_i),
      .wb_data_i (wb_data_i),
      .dec_o     (dec_if.source)
   );

   id_ex #(.DATA_WIDTH(DATA_WIDTH)) pipe_reg (
      .clock   (clock),
      .reset   (reset),
      .flush_i (flush_i),
      .dec_i   (dec_if.sink),
      .ex_o    (ex_if.source)
   );

   execute_stage #(.DATA_WIDTH(DATA_WIDTH)) execute (
      .ex_i            (ex_if.sink),
      .alu_result_o    (alu_result_o),
      .store_data_o    (store_data_o),
      .branch_target_o (branch_target_o),
      .branch_taken_o  (branch_taken_o),
      .mem_read_o      (mem_read_o),
      .mem_write_o     (mem_write_o),
      .mem2reg_o       (mem2reg_o),
      .reg_write_o     (reg_write_o),
      .write_reg_o     (write_reg_o),
      .ex_rn_o         (ex_rn_o),
      .ex_rm_o         (ex_rm_o)
   );

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
#(
   parameter int DATA_WIDTH = 64
)
(
   id_ex_if.sink                            ex_i,
   output logic [DATA_WIDTH-1:0]            alu_result_o,
   output logic [DATA_WIDTH-1:0]            store_data_o,
   output logic [DATA_WIDTH-1:0]            branch_target_o,
   output logic                             branch_taken_o,
   output logic                             mem_read_o,
   output logic                             mem_write_o,
   output logic                             mem2reg_o,
   output logic                             reg_write_o,
   output logic [legv8_pkg::REG_IDX_W-1:0]  write_reg_o,
   output logic [legv8_pkg::REG_IDX_W-1:0]  ex_rn_o,
   output logic [legv8_pkg::REG_IDX_W-1:0]  ex_rm_o
);

   legv8_pkg::alu_fn_e     alu_fn;
   logic [DATA_WIDTH-1:0]  op_b;
   logic [DATA_WIDTH-1:0]  alu_out;

   // ALU control, the field is the top byte of the instruction
   always_comb
   begin
      alu_fn = legv8_pkg::FN_ADD;
      if (ex_i.aluop == legv8_pkg::ALUOP_FUNC)
      begin
         case (ex_i.alu_ctrl)
            legv8_pkg::OP_SUB[10:3], legv8_pkg::OP_SUBI[9:2]: alu_fn = legv8_pkg::FN_SUB;
            legv8_pkg::OP_AND[10:3]:                          alu_fn = legv8_pkg::FN_AND;
            legv8_pkg::OP_ORR[10:3]:                          alu_fn = legv8_pkg::FN_ORR;
            default:                                          alu_fn = legv8_pkg::FN_ADD;
         endcase
      end
   end

   assign op_b = ex_i.alusrc ? ex_i.sign_extended : ex_i.read_data2;

   always_comb
   begin
      case (alu_fn)
         legv8_pkg::FN_SUB: alu_out = ex_i.read_data1 - op_b;
         legv8_pkg::FN_AND: alu_out = ex_i.read_data1 & op_b;
         legv8_pkg::FN_ORR: alu_out = ex_i.read_data1 | op_b;
         default:           alu_out = ex_i.read_data1 + op_b;
      endcase
   end

   // CBZ tests rt, which arrives as operand b
   assign alu_result_o    = (ex_i.aluop == legv8_pkg::ALUOP_PASSB) ? op_b : alu_out;
   assign branch_taken_o  = ex_i.branch_en && (alu_result_o == '0);
   assign branch_target_o = ex_i.pc + (ex_i.sign_extended << 2);

   assign store_data_o = ex_i.read_data2;
   assign mem_read_o   = ex_i.mem_read;
   assign mem_write_o  = ex_i.mem_write;
   assign mem2reg_o    = ex_i.mem2reg;
   assign reg_write_o  = ex_i.reg_write;
   assign write_reg_o  = ex_i.write_reg;
   assign ex_rn_o      = ex_i.rn;
   assign ex_rm_o      = ex_i.rm;

endmodule

// File: design/id_ex.sv
`timescale 1ns/1ns

module id_ex
#(
   parameter int DATA_WIDTH = 64
)
(
   input  logic    clock,
   input  logic    reset,
   input  logic    flush_i,
   id_ex_if.sink   dec_i,
   id_ex_if.source ex_o
);

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         ex_o.aluop         <= legv8_pkg::ALUOP_ADD;
         ex_o.alusrc        <= 1'b0;
         ex_o.branch_en     <= 1'b0;
         ex_o.mem_write     <= 1'b0;
         ex_o.mem_read      <= 1'b0;
         ex_o.mem2reg       <= 1'b0;
         ex_o.reg_write     <= 1'b0;
         ex_o.pc            <= '0;
         ex_o.read_data1    <= '0;
         ex_o.read_data2    <= '0;
         ex_o.sign_extended <= '0;
         ex_o.alu_ctrl      <= '0;
         ex_o.rm            <= '0;
         ex_o.rn            <= '0;
         ex_o.write_reg     <= '0;
      end
      else
      begin
         // a flush drops the controls, data still loads
         if (flush_i)
         begin
            ex_o.aluop     <= legv8_pkg::ALUOP_ADD;
            ex_o.alusrc    <= 1'b0;
            ex_o.branch_en <= 1'b0;
            ex_o.mem_write <= 1'b0;
            ex_o.mem_read  <= 1'b0;
            ex_o.mem2reg   <= 1'b0;
            ex_o.reg_write <= 1'b0;
         end
         else
         begin
            ex_o.aluop     <= dec_i.aluop;
            ex_o.alusrc    <= dec_i.alusrc;
            ex_o.branch_en <= dec_i.branch_en;
            ex_o.mem_write <= dec_i.mem_write;
            ex_o.mem_read  <= dec_i.mem_read;
            ex_o.mem2reg   <= dec_i.mem2reg;
            ex_o.reg_write <= dec_i.reg_write;
         end
         ex_o.pc            <= dec_i.pc;
         ex_o.read_data1    <= dec_i.read_data1;
         ex_o.read_data2    <= dec_i.read_data2;
         ex_o.sign_extended <= dec_i.sign_extended;
         ex_o.alu_ctrl      <= dec_i.alu_ctrl;
         ex_o.rm            <= dec_i.rm;
         ex_o.rn            <= dec_i.rn;
         ex_o.write_reg     <= dec_i.write_reg;
      end
   end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
#(
   parameter int DATA_WIDTH = 64
)
(
   input  logic                             clock,
   input  logic                             reset,
   input  logic [31:0]                      instr_i,
   input  logic [DATA_WIDTH-1:0]            pc_i,
   input  logic                             wb_en_i,
   input  logic [legv8_pkg::REG_IDX_W-1:0]  wb_reg_i,
   input  logic [DATA_WIDTH-1:0]            wb_data_i,
   id_ex_if.source                          dec_o
);

   localparam int IW = legv8_pkg::REG_IDX_W;

   legv8_pkg::insn_u       insn;
   logic                   is_r;
   logic                   is_i;
   logic                   is_ldur;
   logic                   is_stur;
   logic                   is_cbz;
   logic [IW-1:0]          src_b_idx;
   logic [DATA_WIDTH-1:0]  rd_data_a;
   logic [DATA_WIDTH-1:0]  rd_data_b;

   assign insn = instr_i;

   // each format compares its own opcode width
   assign is_r    = (insn.r.opcode == legv8_pkg::OP_ADD) ||
                    (insn.r.opcode == legv8_pkg::OP_SUB) ||
                    (insn.r.opcode == legv8_pkg::OP_AND) ||
                    (insn.r.opcode == legv8_pkg::OP_ORR);
   assign is_i    = (insn.i.opcode == legv8_pkg::OP_ADDI) ||
                    (insn.i.opcode == legv8_pkg::OP_SUBI);
   assign is_ldur = (insn.d.opcode == legv8_pkg::OP_LDUR);
   assign is_stur = (insn.d.opcode == legv8_pkg::OP_STUR);
   assign is_cbz  = (insn.cb.opcode == legv8_pkg::OP_CBZ);

   // port b reads rm for R-type, rt otherwise
   assign src_b_idx = is_r ? insn.r.rm[IW-1:0] : insn.d.rt[IW-1:0];

   register_file #(
      .DATA_WIDTH (DATA_WIDTH)
   ) regfile (
      .clock       (clock),
      .reset       (reset),
      .rd_idx_a_i  (insn.r.rn[IW-1:0]),
      .rd_idx_b_i  (src_b_idx),
      .rd_data_a_o (rd_data_a),
      .rd_data_b_o (rd_data_b),
      .wr_en_i     (wb_en_i),
      .wr_idx_i    (wb_reg_i),
      .wr_data_i   (wb_data_i)
   );

   assign dec_o.pc         = pc_i;
   assign dec_o.read_data1 = rd_data_a;
   assign dec_o.read_data2 = rd_data_b;
   assign dec_o.alu_ctrl   = insn.cb.opcode;
   assign dec_o.rn         = insn.r.rn[IW-1:0];
   assign dec_o.rm         = insn.r.rm[IW-1:0];

   // rd and rt sit in the same low field of every format
   assign dec_o.write_reg  = insn.r.rd[IW-1:0];

   always_comb
   begin
      // unmatched opcodes leave a bubble
      dec_o.aluop         = legv8_pkg::ALUOP_ADD;
      dec_o.alusrc        = 1'b0;
      dec_o.branch_en     = 1'b0;
      dec_o.mem_write     = 1'b0;
      dec_o.mem_read      = 1'b0;
      dec_o.mem2reg       = 1'b0;
      dec_o.reg_write     = 1'b0;
      dec_o.sign_extended = '0;
      if (is_r)
      begin
         dec_o.aluop     = legv8_pkg::ALUOP_FUNC;
         dec_o.reg_write = 1'b1;
      end
      else if (is_i)
      begin
         dec_o.aluop         = legv8_pkg::ALUOP_FUNC;
         dec_o.alusrc        = 1'b1;
         dec_o.reg_write     = 1'b1;
         dec_o.sign_extended = {{(DATA_WIDTH-12){1'b0}}, insn.i.imm12};
      end
      else if (is_ldur || is_stur)
      begin
         dec_o.alusrc        = 1'b1;
         dec_o.mem_read      = is_ldur;
         dec_o.mem2reg       = is_ldur;
         dec_o.reg_write     = is_ldur;
         dec_o.mem_write     = is_stur;
         dec_o.sign_extended = {{(DATA_WIDTH-9){insn.d.address[8]}}, insn.d.address};
      end
      else if (is_cbz)
      begin
         dec_o.aluop         = legv8_pkg::ALUOP_PASSB;
         dec_o.branch_en     = 1'b1;
         dec_o.sign_extended = {{(DATA_WIDTH-19){insn.cb.address[18]}}, insn.cb.address};
      end
   end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ns

module register_file
#(
   parameter int DATA_WIDTH = 64
)
(
   input  logic                             clock,
   input  logic                             reset,
   input  logic [legv8_pkg::REG_IDX_W-1:0]  rd_idx_a_i,
   input  logic [legv8_pkg::REG_IDX_W-1:0]  rd_idx_b_i,
   output logic [DATA_WIDTH-1:0]            rd_data_a_o,
   output logic [DATA_WIDTH-1:0]            rd_data_b_o,
   input  logic                             wr_en_i,
   input  logic [legv8_pkg::REG_IDX_W-1:0]  wr_idx_i,
   input  logic [DATA_WIDTH-1:0]            wr_data_i
);

   localparam int NUM_REGS = 2 ** legv8_pkg::REG_IDX_W;

   logic [DATA_WIDTH-1:0] regs [NUM_REGS];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int k = 0; k < NUM_REGS; k++)
         begin
            regs[k] <= '0;
         end
      end
      else if (wr_en_i)
      begin
         regs[wr_idx_i] <= wr_data_i;
      end
   end

   // same-cycle write is visible to the decoding instruction
   assign rd_data_a_o = (wr_en_i && (wr_idx_i == rd_idx_a_i)) ? wr_data_i
                                                              : regs[rd_idx_a_i];
   assign rd_data_b_o = (wr_en_i && (wr_idx_i == rd_idx_b_i)) ? wr_data_i
                                                              : regs[rd_idx_b_i];

endmodule

// File: design/id_ex_if.sv
`timescale 1ns/1ns

interface id_ex_if
#(
   parameter int DATA_WIDTH = 64
);

   localparam int IW = legv8_pkg::REG_IDX_W;

   // execute controls
   legv8_pkg::aluop_e      aluop;
   logic                   alusrc;
   logic                   branch_en;

   // memory and writeback controls
   logic                   mem_write;
   logic                   mem_read;
   logic                   mem2reg;
   logic                   reg_write;

   // operands
   logic [DATA_WIDTH-1:0]  pc;
   logic [DATA_WIDTH-1:0]  read_data1;
   logic [DATA_WIDTH-1:0]  read_data2;
   logic [DATA_WIDTH-1:0]  sign_extended;
   logic [7:0]             alu_ctrl;
   logic [IW-1:0]          rm;
   logic [IW-1:0]          rn;
   logic [IW-1:0]          write_reg;

   modport source (
      output aluop, alusrc, branch_en, mem_write, mem_read, mem2reg, reg_write,
      output pc, read_data1, read_data2, sign_extended, alu_ctrl, rm, rn, write_reg
   );

   modport sink (
      input aluop, alusrc, branch_en, mem_write, mem_read, mem2reg, reg_write,
      input pc, read_data1, read_data2, sign_extended, alu_ctrl, rm, rn, write_reg
   );

endinterface

// File: design/legv8_pkg.sv
package legv8_pkg;

   // register index width, 16 registers and no zero register
   localparam int REG_IDX_W = 4;

   // R-type opcodes
   localparam logic [10:0] OP_ADD  = 11'b100_0101_1000;
   localparam logic [10:0] OP_SUB  = 11'b110_0101_1000;
   localparam logic [10:0] OP_AND  = 11'b100_0101_0000;
   localparam logic [10:0] OP_ORR  = 11'b101_0101_0000;

   // I-type opcodes
   localparam logic [9:0]  OP_ADDI = 10'b10_0100_0100;
   localparam logic [9:0]  OP_SUBI = 10'b11_0100_0100;

   // D-type opcodes
   localparam logic [10:0] OP_LDUR = 11'b111_1100_0010;
   localparam logic [10:0] OP_STUR = 11'b111_1100_0000;

   // CB-type opcode
   localparam logic [7:0]  OP_CBZ  = 8'b1011_0100;

   typedef struct packed {
      logic [10:0] opcode;
      logic [4:0]  rm;
      logic [5:0]  shamt;
      logic [4:0]  rn;
      logic [4:0]  rd;
   } r_fmt_t;

   typedef struct packed {
      logic [9:0]  opcode;
      logic [11:0] imm12;
      logic [4:0]  rn;
      logic [4:0]  rd;
   } i_fmt_t;

   typedef struct packed {
      logic [10:0] opcode;
      logic [8:0]  address;
      logic [1:0]  op;
      logic [4:0]  rn;
      logic [4:0]  rt;
   } d_fmt_t;

   typedef struct packed {
      logic [7:0]  opcode;
      logic [18:0] address;
      logic [4:0]  rt;
   } cb_fmt_t;

   // one instruction word seen through each format
   typedef union packed {
      r_fmt_t  r;
      i_fmt_t  i;
      d_fmt_t  d;
      cb_fmt_t cb;
   } insn_u;

   typedef enum logic [1:0] {
      ALUOP_ADD   = 2'b00,
      ALUOP_PASSB = 2'b01,
      ALUOP_FUNC  = 2'b10
   } aluop_e;

   typedef enum logic [1:0] {
      FN_ADD = 2'b00,
      FN_SUB = 2'b01,
      FN_AND = 2'b10,
      FN_ORR = 2'b11
   } alu_fn_e;

endpackage
